//--- common/kv_config_pkg.sv
// key-value node configuration types
// route table entry, the configuration bundle driven to the node,
// and the enums used between the ring decoder and the table sequencer

`default_nettype none

package kv_config_pkg;

   localparam int NUM_QUEUES = 5;   // width of the output queue field

   // one route table entry
   typedef struct packed {
      logic [31:0]           ip;
      logic [31:0]           mask;
      logic [31:0]           next_hop;
      logic [NUM_QUEUES-1:0] oq;
   } route_entry_t;

   // =====================================================================
   // configuration levels to the rest of the node
   // =====================================================================
   typedef struct packed {
      logic [31:0] num_keys;
      logic [31:0] shard_id;
      logic [1:0]  log_2_num_workers;   // used for key hash masking
      logic [31:0] max_n_values;
      logic [31:0] filter_threshold;
      logic [31:0] interpkt_gap_cycles; // gap between two put packets
      logic [3:0]  max_fpga_procs;
      logic        algo_selection;
      logic [7:0]  proc_bit_mask;
   } kv_config_t;

   // what the decoder made of the current ring word
   typedef enum logic [2:0] {
      RING_PASS,
      RING_LOCAL_READ,
      RING_BAD_ADDR,
      RING_LOCAL_WRITE,
      RING_IGNORE
   } ring_kind_e;

   // route table sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_RT_WRITE,
      SEQ_RT_READ,
      SEQ_DONE
   } seq_state_e;

endpackage

`default_nettype wire

//--- common/reg_ring_pkg.sv
// register ring definitions shared by every block on the daisy chain
// holds the bus widths, the ring word and this block's tag and offsets
// import into a module body, or use scoped names in port lists

`default_nettype none

package reg_ring_pkg;

   // =====================================================================
   // bus widths
   // =====================================================================
   localparam int REG_ADDR_WIDTH   = 23;
   localparam int REG_DATA_WIDTH   = 32;
   localparam int REG_SRC_WIDTH    = 2;
   localparam int REG_OFFSET_WIDTH = 6;   // register select inside a block
   localparam int REG_TAG_WIDTH    = REG_ADDR_WIDTH - REG_OFFSET_WIDTH;

   // upper address bits that select the op lut register block
   localparam logic [REG_TAG_WIDTH-1:0] BLOCK_TAG = 17'h00021;

   // one word on the ring, msb first
   typedef struct packed {
      logic                      req;      // valid for one cycle
      logic                      ack;      // request served
      logic                      rd_wr_l;  // high = read
      logic [REG_ADDR_WIDTH-1:0] addr;
      logic [REG_DATA_WIDTH-1:0] data;
      logic [REG_SRC_WIDTH-1:0]  src;
   } reg_ring_t;

   // register offsets of this block, anything above 9 is a bad address
   typedef enum logic [REG_OFFSET_WIDTH-1:0] {
      OFS_SHARD_ID    = 6'd0,
      OFS_NUM_WORKERS = 6'd1,
      OFS_NUM_KEYS    = 6'd2,
      OFS_RT_IP       = 6'd3,
      OFS_RT_MASK     = 6'd4,
      OFS_RT_NEXT_HOP = 6'd5,
      OFS_RT_OQ       = 6'd6,
      OFS_RT_RD_ADDR  = 6'd7,
      OFS_RT_WR_ADDR  = 6'd8,
      OFS_ALGO_SELECT = 6'd9
   } reg_offset_e;

endpackage

`default_nettype wire

//--- op_lut/config_reg_file.sv
// configuration and route entry registers of the op lut block
// written from the ring, read back through the mux, and loaded with
// a route table entry when a table read completes
// the node configuration is derived combinationally from the registers

`timescale 1ns/10ps
`default_nettype none

module config_reg_file #(
   parameter int LPM_LUT_DEPTH_BITS = 4
) (
   input  wire                              clk,
   input  wire                              reset,
   input  kv_config_pkg::ring_kind_e        kind,
   input  reg_ring_pkg::reg_offset_e        offset,
   input  wire [31:0]                       wr_data,
   input  wire                              rt_rd_done,   // entry valid from table
   input  kv_config_pkg::route_entry_t      rt_rd_entry,
   output logic [31:0]                      rd_data,
   output logic [LPM_LUT_DEPTH_BITS-1:0]    rt_rd_addr,
   output logic [LPM_LUT_DEPTH_BITS-1:0]    rt_wr_addr,
   output kv_config_pkg::route_entry_t      rt_wr_entry,
   output kv_config_pkg::kv_config_t        kv_config
);
   import reg_ring_pkg::*;
   import kv_config_pkg::*;

   logic [31:0]  shard_id;
   logic [31:0]  num_workers;
   logic [31:0]  num_keys;
   logic         algo_select;
   route_entry_t rt_entry;        // also carries gap, threshold and max values
   logic [3:0]   procs;

   // =====================================================================
   // register writes and table read loads
   // =====================================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         shard_id    <= '0;
         num_workers <= '0;
         num_keys    <= '0;
         algo_select <= 1'b0;
         rt_entry    <= '0;
         rt_rd_addr  <= '0;
         rt_wr_addr  <= '0;
      end else if (rt_rd_done) begin
         rt_entry <= rt_rd_entry;
      end else if (kind == RING_LOCAL_WRITE) begin
         case (offset)
            OFS_SHARD_ID:    shard_id          <= wr_data;
            OFS_NUM_WORKERS: num_workers       <= wr_data;
            OFS_NUM_KEYS:    num_keys          <= wr_data;
            OFS_RT_IP:       rt_entry.ip       <= wr_data;
            OFS_RT_MASK:     rt_entry.mask     <= wr_data;
            OFS_RT_NEXT_HOP: rt_entry.next_hop <= wr_data;
            OFS_RT_OQ:       rt_entry.oq       <= wr_data[NUM_QUEUES-1:0];
            OFS_RT_RD_ADDR:  rt_rd_addr        <= wr_data[LPM_LUT_DEPTH_BITS-1:0];
            OFS_RT_WR_ADDR:  rt_wr_addr        <= wr_data[LPM_LUT_DEPTH_BITS-1:0];
            OFS_ALGO_SELECT: algo_select       <= wr_data[0];
            default: ;
         endcase
      end
   end

   // read mux, narrow registers zero-extended
   always_comb begin
      case (offset)
         OFS_SHARD_ID:    rd_data = shard_id;
         OFS_NUM_WORKERS: rd_data = num_workers;
         OFS_NUM_KEYS:    rd_data = num_keys;
         OFS_RT_IP:       rd_data = rt_entry.ip;
         OFS_RT_MASK:     rd_data = rt_entry.mask;
         OFS_RT_NEXT_HOP: rd_data = rt_entry.next_hop;
         OFS_RT_OQ:       rd_data = 32'(rt_entry.oq);
         OFS_RT_RD_ADDR:  rd_data = 32'(rt_rd_addr);
         OFS_RT_WR_ADDR:  rd_data = 32'(rt_wr_addr);
         OFS_ALGO_SELECT: rd_data = 32'(algo_select);
         default:         rd_data = '0;
      endcase
   end

   assign rt_wr_entry = rt_entry;

   // =====================================================================
   // derived configuration
   // =====================================================================
   assign procs = rt_entry.oq[3:0];

   always_comb begin
      kv_config.num_keys            = num_keys;
      kv_config.shard_id            = shard_id;
      case (num_workers)           // clusters of up to 8 workers
         32'd2:   kv_config.log_2_num_workers = 2'd1;
         32'd4:   kv_config.log_2_num_workers = 2'd2;
         32'd8:   kv_config.log_2_num_workers = 2'd3;
         default: kv_config.log_2_num_workers = 2'd0;
      endcase
      kv_config.max_n_values        = rt_entry.ip;
      kv_config.filter_threshold    = rt_entry.mask;
      kv_config.interpkt_gap_cycles = rt_entry.next_hop;
      kv_config.max_fpga_procs      = procs;
      kv_config.algo_selection      = algo_select;
      if (procs >= 4'd8) begin
         kv_config.proc_bit_mask = 8'hff;
      end else begin
         kv_config.proc_bit_mask = ~(8'hff << procs);   // low procs bits set
      end
   end

endmodule

`default_nettype wire

//--- op_lut/route_table_sequencer.sv
// route table access sequencer
// starts on a local write, runs the table write or read handshake for
// the table address registers and signals done for the ring answer
// requests are levels held until the matching ack is seen

`timescale 1ns/10ps
`default_nettype none

module route_table_sequencer (
   input  wire                         clk,
   input  wire                         reset,
   input  kv_config_pkg::ring_kind_e   kind,
   input  reg_ring_pkg::reg_offset_e   offset,
   output logic                        busy,
   output logic                        done,
   output logic                        rt_rd_done,   // load entry registers
   output logic                        rt_wr_req,
   output logic                        rt_rd_req,
   input  wire                         rt_wr_ack,
   input  wire                         rt_rd_ack
);
   import reg_ring_pkg::*;
   import kv_config_pkg::*;

   seq_state_e state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= SEQ_IDLE;
         rt_wr_req <= 1'b0;
         rt_rd_req <= 1'b0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (kind == RING_LOCAL_WRITE) begin
                  case (offset)
                     OFS_RT_WR_ADDR: state <= SEQ_RT_WRITE;
                     OFS_RT_RD_ADDR: state <= SEQ_RT_READ;
                     default:        state <= SEQ_DONE;   // plain register
                  endcase
               end
            end
            SEQ_RT_WRITE: begin
               if (rt_wr_ack) begin
                  state     <= SEQ_DONE;
                  rt_wr_req <= 1'b0;
               end else begin
                  rt_wr_req <= 1'b1;   // waits on the table indefinitely
               end
            end
            SEQ_RT_READ: begin
               if (rt_rd_ack) begin
                  state     <= SEQ_DONE;
                  rt_rd_req <= 1'b0;
               end else begin
                  rt_rd_req <= 1'b1;
               end
            end
            default: begin
               state <= SEQ_IDLE;      // one cycle of done
            end
         endcase
      end
   end

   assign busy       = (state != SEQ_IDLE);
   assign done       = (state == SEQ_DONE);
   assign rt_rd_done = (state == SEQ_RT_READ) && rt_rd_ack;

endmodule

`default_nettype wire

//--- op_lut_regs.f
+incdir+test
common/reg_ring_pkg.sv
common/kv_config_pkg.sv
reg_ring/reg_ring_decoder.sv
reg_ring/reg_ring_driver.sv
op_lut/config_reg_file.sv
op_lut/route_table_sequencer.sv
source/op_lut_regs.sv
test/op_lut_regs_tb.sv

//--- reg_ring/reg_ring_decoder.sv
// ring input side
// splits the incoming address into tag and offset, classifies the word
// for the rest of the block and keeps a copy of an accepted local write
// so that the final answer can repeat it

`timescale 1ns/10ps
`default_nettype none

module reg_ring_decoder (
   input  wire                        clk,
   input  wire                        reset,
   input  reg_ring_pkg::reg_ring_t    ring_in,
   input  wire                        busy,      // table access in progress
   output kv_config_pkg::ring_kind_e  kind,
   output reg_ring_pkg::reg_offset_e  offset,
   output reg_ring_pkg::reg_ring_t    held
);
   import reg_ring_pkg::*;
   import kv_config_pkg::*;

   logic [REG_TAG_WIDTH-1:0]    tag;
   logic [REG_OFFSET_WIDTH-1:0] ofs_raw;
   logic                        tag_hit;
   logic                        addr_good;

   assign tag       = ring_in.addr[REG_ADDR_WIDTH-1:REG_OFFSET_WIDTH];
   assign ofs_raw   = ring_in.addr[REG_OFFSET_WIDTH-1:0];
   assign offset    = reg_offset_e'(ofs_raw);
   assign tag_hit   = (tag == BLOCK_TAG);
   assign addr_good = (ofs_raw <= REG_OFFSET_WIDTH'(OFS_ALGO_SELECT));

   // =====================================================================
   // classification
   // =====================================================================
   always_comb begin
      if (busy) begin
         kind = RING_IGNORE;              // one outstanding transaction only
      end else if (!ring_in.req || !tag_hit) begin
         kind = RING_PASS;
      end else if (!addr_good) begin
         kind = RING_BAD_ADDR;            // reads and writes alike
      end else if (ring_in.rd_wr_l) begin
         kind = RING_LOCAL_READ;
      end else begin
         kind = RING_LOCAL_WRITE;
      end
   end

   // copy of the write, replayed with ack when the sequencer is done
   always_ff @(posedge clk) begin
      if (reset) begin
         held <= '0;
      end else if (kind == RING_LOCAL_WRITE) begin
         held <= ring_in;
      end
   end

endmodule

`default_nettype wire

//--- reg_ring/reg_ring_driver.sv
// ring output side
// registers the word sent downstream: pass-through, read answer,
// bad address answer, the zero word of an accepted write and the
// final write answer once the sequencer is done

`timescale 1ns/10ps
`default_nettype none

module reg_ring_driver (
   input  wire                                      clk,
   input  wire                                      reset,
   input  kv_config_pkg::ring_kind_e                kind,
   input  reg_ring_pkg::reg_ring_t                  ring_in,
   input  wire [reg_ring_pkg::REG_DATA_WIDTH-1:0]   rd_data,
   input  reg_ring_pkg::reg_ring_t                  held,
   input  wire                                      done,
   output reg_ring_pkg::reg_ring_t                  ring_out
);
   import kv_config_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         ring_out <= '0;
      end else if (done) begin
         // write finished, send the original word back served
         ring_out     <= held;
         ring_out.req <= 1'b1;
         ring_out.ack <= 1'b1;
      end else begin
         case (kind)
            RING_PASS: begin
               ring_out <= ring_in;     // foreign or idle word
            end
            RING_LOCAL_READ: begin
               ring_out      <= ring_in;
               ring_out.req  <= 1'b1;
               ring_out.ack  <= 1'b1;
               ring_out.data <= rd_data;
            end
            RING_BAD_ADDR: begin
               ring_out     <= ring_in;  // data goes back untouched
               ring_out.req <= 1'b1;
               ring_out.ack <= 1'b0;
            end
            RING_LOCAL_WRITE: begin
               ring_out <= '0;          // answer comes with done
            end
            default: begin
               ring_out <= ring_out;    // busy, keep the zero word
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the op lut testbench with Verilator and run it
set -e

verilator --binary --timing --assert -f op_lut_regs.f \
   --top-module op_lut_regs_tb -o Vop_lut_regs_tb

output=$(./obj_dir/Vop_lut_regs_tb)
echo "$output"

if echo "$output" | grep -q "^Simulation PASSED$"; then
   exit 0
fi
exit 1

//--- source/op_lut_regs.sv
// op lut configuration register block of a key-value accelerator node
// sits on the register ring, serves its own tag and passes the rest on
// drives the node configuration and the route table access handshakes

`timescale 1ns/10ps
`default_nettype none

module op_lut_regs #(
   parameter int LPM_LUT_DEPTH_BITS = 4
) (
   input  wire                                 clk,
   input  wire                                 reset,
   input  reg_ring_pkg::reg_ring_t             ring_in,
   output reg_ring_pkg::reg_ring_t             ring_out,
   output logic [LPM_LUT_DEPTH_BITS-1:0]       rt_rd_addr,
   output logic [LPM_LUT_DEPTH_BITS-1:0]       rt_wr_addr,
   output logic                                rt_rd_req,
   input  wire                                 rt_rd_ack,
   input  kv_config_pkg::route_entry_t         rt_rd_entry,
   output logic                                rt_wr_req,
   input  wire                                 rt_wr_ack,
   output kv_config_pkg::route_entry_t         rt_wr_entry,
   output kv_config_pkg::kv_config_t           kv_config
);
   import reg_ring_pkg::*;
   import kv_config_pkg::*;

   ring_kind_e                kind;
   reg_offset_e               offset;
   reg_ring_t                 held;        // accepted local write
   logic                      busy;
   logic                      done;
   logic                      rt_rd_done;
   logic [REG_DATA_WIDTH-1:0] rd_data;

   reg_ring_decoder i_reg_ring_decoder (
      .clk(clk), .reset(reset), .ring_in(ring_in), .busy(busy),
      .kind(kind), .offset(offset), .held(held)
   );

   config_reg_file #(
      .LPM_LUT_DEPTH_BITS(LPM_LUT_DEPTH_BITS)
   ) i_config_reg_file (
      .clk(clk), .reset(reset), .kind(kind), .offset(offset),
      .wr_data(ring_in.data), .rt_rd_done(rt_rd_done), .rt_rd_entry(rt_rd_entry),
      .rd_data(rd_data), .rt_rd_addr(rt_rd_addr), .rt_wr_addr(rt_wr_addr),
      .rt_wr_entry(rt_wr_entry), .kv_config(kv_config)
   );

   route_table_sequencer i_route_table_sequencer (
      .clk(clk), .reset(reset), .kind(kind), .offset(offset),
      .busy(busy), .done(done), .rt_rd_done(rt_rd_done),
      .rt_wr_req(rt_wr_req), .rt_rd_req(rt_rd_req),
      .rt_wr_ack(rt_wr_ack), .rt_rd_ack(rt_rd_ack)
   );

   reg_ring_driver i_reg_ring_driver (
      .clk(clk), .reset(reset), .kind(kind), .ring_in(ring_in),
      .rd_data(rd_data), .held(held), .done(done), .ring_out(ring_out)
   );

endmodule

`default_nettype wire

//--- test/tb_ring_tasks.svh
// ring access tasks, random numbers and value checks for the op lut testbench
// included inside the testbench module body, after its signals and counters

// 32 bit linear congruential generator
function automatic logic [31:0] next_rand();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
   check_count++;
   assert (got === expected)
   else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      error_count++;
   end
endtask

// ring word with req set and ack clear
function automatic reg_ring_t make_word(input logic rd, input logic [REG_TAG_WIDTH-1:0] tag,
                                        input logic [5:0] ofs, input logic [31:0] data);
   reg_ring_t w;
   w         = '0;
   w.req     = 1'b1;
   w.rd_wr_l = rd;
   w.addr    = {tag, ofs};
   w.data    = data;
   w.src     = 2'd1;
   return w;
endfunction

// one cycle on ring_in, returns on the falling edge after the DUT took it
task automatic drive_word(input reg_ring_t w);
   ring_in = w;
   @(negedge clk);
   ring_in = '0;
endtask

// cycles count from the drive of the write
task automatic wait_answer(output int cycles);
   cycles = 1;
   do begin
      @(negedge clk);
      cycles++;
   end while (!(ring_out.req && ring_out.ack) && cycles < TIMEOUT_CYCLES);
   if (!(ring_out.req && ring_out.ack)) begin
      $display("Timeout at %0t ns: the write was never answered on ring_out", $time);
      error_count++;
   end
endtask

task automatic ring_write(input logic [5:0] ofs, input logic [31:0] data, input bit timed);
   reg_ring_t w;
   reg_ring_t expected;
   int        cycles;
   w            = make_word(1'b0, BLOCK_TAG, ofs, data);
   expected     = w;
   expected.ack = 1'b1;
   drive_word(w);
   check_value("ring_out while write pending", 64'(ring_out), 64'd0);
   wait_answer(cycles);
   check_value("ring_out write answer", 64'(ring_out), 64'(expected));
   if (timed) begin
      check_value("write answer latency", 64'(cycles), 64'd2);
   end
   note_write(ofs, data);
endtask

task automatic read_check(input logic [5:0] ofs);
   reg_ring_t w;
   reg_ring_t expected;
   w             = make_word(1'b1, BLOCK_TAG, ofs, next_rand());
   expected      = w;
   expected.ack  = 1'b1;
   expected.data = read_value(ofs);
   drive_word(w);
   check_value($sformatf("ring_out read of offset %0d", ofs), 64'(ring_out), 64'(expected));
endtask

//--- test/op_lut_regs_tb.sv
// testbench for the op lut register block
// drives ring requests, answers the route table handshakes with a small
// memory model and checks ring answers and the node configuration

`timescale 1ns/10ps
`default_nettype none

module op_lut_regs_tb;
   import reg_ring_pkg::*;
   import kv_config_pkg::*;

   localparam int DEPTH_BITS     = 4;
   localparam int TIMEOUT_CYCLES = 100;
   localparam logic [REG_TAG_WIDTH-1:0] FOREIGN_TAG = 17'h00035;

   logic                  clk;
   logic                  reset;
   reg_ring_t             ring_in;
   reg_ring_t             ring_out;
   logic [DEPTH_BITS-1:0] rt_rd_addr;
   logic [DEPTH_BITS-1:0] rt_wr_addr;
   logic                  rt_rd_req;
   logic                  rt_rd_ack;
   route_entry_t          rt_rd_entry;
   logic                  rt_wr_req;
   logic                  rt_wr_ack;
   route_entry_t          rt_wr_entry;
   kv_config_t            kv_config;

   logic [31:0]  lcg_state = 32'h0af1383b;
   int           error_count = 0;
   int           check_count = 0;
   int           test_count = 0;
   int           test_errors;
   string        test_name;
   route_entry_t table_mem [2**DEPTH_BITS];
   route_entry_t seen_wr_entry;                // what the table was asked to store
   logic [DEPTH_BITS-1:0] seen_wr_addr;
   logic [DEPTH_BITS-1:0] seen_rd_addr;
   int           wr_req_count;
   int           rd_req_count;

   // expected register contents
   logic [31:0]  sh_shard = '0;
   logic [31:0]  sh_workers = '0;
   logic [31:0]  sh_keys = '0;
   route_entry_t sh_entry = '0;
   logic         sh_algo = 1'b0;
   logic [DEPTH_BITS-1:0] sh_rd_addr = '0;
   logic [DEPTH_BITS-1:0] sh_wr_addr = '0;

   logic [5:0]   plain_ofs [8] = '{OFS_SHARD_ID, OFS_NUM_WORKERS, OFS_NUM_KEYS, OFS_RT_IP,
                                   OFS_RT_MASK, OFS_RT_NEXT_HOP, OFS_RT_OQ, OFS_ALGO_SELECT};
   logic [31:0]  worker_counts [5] = '{32'd1, 32'd2, 32'd4, 32'd8, 32'd3};
   logic [31:0]  proc_counts [4] = '{32'd0, 32'd3, 32'd8, 32'd12};

   // =====================================================================
   // register rules
   // =====================================================================
   task automatic note_write(input logic [5:0] ofs, input logic [31:0] data);
      case (ofs)
         OFS_SHARD_ID:    sh_shard          = data;
         OFS_NUM_WORKERS: sh_workers        = data;
         OFS_NUM_KEYS:    sh_keys           = data;
         OFS_RT_IP:       sh_entry.ip       = data;
         OFS_RT_MASK:     sh_entry.mask     = data;
         OFS_RT_NEXT_HOP: sh_entry.next_hop = data;
         OFS_RT_OQ:       sh_entry.oq       = data[NUM_QUEUES-1:0];   // 5 bit queue field
         OFS_RT_RD_ADDR:  sh_rd_addr        = data[DEPTH_BITS-1:0];
         OFS_RT_WR_ADDR:  sh_wr_addr        = data[DEPTH_BITS-1:0];
         OFS_ALGO_SELECT: sh_algo           = data[0];
         default: ;
      endcase
   endtask

   function automatic logic [31:0] read_value(input logic [5:0] ofs);
      case (ofs)
         OFS_SHARD_ID:    return sh_shard;
         OFS_NUM_WORKERS: return sh_workers;
         OFS_NUM_KEYS:    return sh_keys;
         OFS_RT_IP:       return sh_entry.ip;
         OFS_RT_MASK:     return sh_entry.mask;
         OFS_RT_NEXT_HOP: return sh_entry.next_hop;
         OFS_RT_OQ:       return 32'(sh_entry.oq);
         OFS_RT_RD_ADDR:  return 32'(sh_rd_addr);
         OFS_RT_WR_ADDR:  return 32'(sh_wr_addr);
         default:         return 32'(sh_algo);
      endcase
   endfunction

   // only exact powers up to 8 give a nonzero log2
   function automatic logic [1:0] expected_log2(input logic [31:0] n);
      if (n == 32'd8) return 2'd3;
      else if (n == 32'd4) return 2'd2;
      else if (n == 32'd2) return 2'd1;
      else return 2'd0;
   endfunction

   function automatic logic [7:0] expected_mask(input logic [3:0] n);
      logic [7:0] m;
      m = '0;
      for (int i = 0; i < 8; i++) begin
         if (i < int'(n)) m[i] = 1'b1;
      end
      return m;
   endfunction

   task automatic check_config();
      check_value("kv_config.num_keys", 64'(kv_config.num_keys), 64'(sh_keys));
      check_value("kv_config.shard_id", 64'(kv_config.shard_id), 64'(sh_shard));
      check_value("kv_config.log_2_num_workers", 64'(kv_config.log_2_num_workers),
                  64'(expected_log2(sh_workers)));
      check_value("kv_config.max_n_values", 64'(kv_config.max_n_values), 64'(sh_entry.ip));
      check_value("kv_config.filter_threshold", 64'(kv_config.filter_threshold),
                  64'(sh_entry.mask));
      check_value("kv_config.interpkt_gap_cycles", 64'(kv_config.interpkt_gap_cycles),
                  64'(sh_entry.next_hop));
      check_value("kv_config.max_fpga_procs", 64'(kv_config.max_fpga_procs),
                  64'(sh_entry.oq[3:0]));
      check_value("kv_config.algo_selection", 64'(kv_config.algo_selection), 64'(sh_algo));
      check_value("kv_config.proc_bit_mask", 64'(kv_config.proc_bit_mask),
                  64'(expected_mask(sh_entry.oq[3:0])));
   endtask

   `include "tb_ring_tasks.svh"

   task automatic write_entry_regs();
      for (int k = 3; k <= 6; k++) begin
         ring_write(6'(k), next_rand(), 1'b1);     // ip, mask, next hop, oq
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = error_count;
   endtask

   task automatic end_test();
      test_count++;
      $display("test %0d %s: %0d errors", test_count, test_name, error_count - test_errors);
   endtask

   op_lut_regs #(
      .LPM_LUT_DEPTH_BITS(DEPTH_BITS)
   ) i_op_lut_regs (
      .clk(clk), .reset(reset), .ring_in(ring_in), .ring_out(ring_out),
      .rt_rd_addr(rt_rd_addr), .rt_wr_addr(rt_wr_addr), .rt_rd_req(rt_rd_req),
      .rt_rd_ack(rt_rd_ack), .rt_rd_entry(rt_rd_entry), .rt_wr_req(rt_wr_req),
      .rt_wr_ack(rt_wr_ack), .rt_wr_entry(rt_wr_entry), .kv_config(kv_config)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // =====================================================================
   // route table model with a random 1 to 4 cycle answer
   // =====================================================================
   initial begin : route_table_model
      int delay;
      rt_wr_ack   = 1'b0;
      rt_rd_ack   = 1'b0;
      rt_rd_entry = '0;
      for (int i = 0; i < 2**DEPTH_BITS; i++) begin
         table_mem[i] = {32'hc0a8_0000 + 32'(i), 32'hffff_ff00 - 32'(i),
                         32'h0a00_0100 + 32'(i), 5'(i)};
      end
      forever begin
         @(negedge clk);
         if (!reset && rt_wr_req) begin
            wr_req_count++;
            seen_wr_entry = rt_wr_entry;
            seen_wr_addr  = rt_wr_addr;
            delay = int'(next_rand() % 32'd4) + 1;
            repeat (delay) @(negedge clk);
            table_mem[rt_wr_addr] = rt_wr_entry;
            rt_wr_ack = 1'b1;
            @(negedge clk);
            rt_wr_ack = 1'b0;
         end else if (!reset && rt_rd_req) begin
            rd_req_count++;
            seen_rd_addr = rt_rd_addr;
            delay = int'(next_rand() % 32'd4) + 1;
            repeat (delay) @(negedge clk);
            rt_rd_entry = table_mem[rt_rd_addr];   // valid with the ack only
            rt_rd_ack   = 1'b1;
            @(negedge clk);
            rt_rd_ack   = 1'b0;
         end
      end
   end

   // =====================================================================
   // tests
   // =====================================================================
   initial begin : main_sequence
      reg_ring_t             w;
      logic [31:0]           data;
      logic [DEPTH_BITS-1:0] table_addr;
      route_entry_t          stored_entry;
      reset   = 1'b1;
      ring_in = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      start_test("reset values");
      check_value("ring_out", 64'(ring_out), 64'd0);
      check_value("rt_wr_req", 64'(rt_wr_req), 64'd0);
      check_value("rt_rd_req", 64'(rt_rd_req), 64'd0);
      check_config();
      end_test();

      start_test("pass-through");
      w = make_word(1'b0, FOREIGN_TAG, 6'(OFS_SHARD_ID), next_rand());
      drive_word(w);
      check_value("ring_out foreign write", 64'(ring_out), 64'(w));
      w = make_word(1'b1, FOREIGN_TAG, 6'd12, next_rand());
      drive_word(w);
      check_value("ring_out foreign read", 64'(ring_out), 64'(w));
      w     = make_word(1'b0, BLOCK_TAG, 6'(OFS_NUM_KEYS), next_rand());
      w.req = 1'b0;                               // own tag but no request
      drive_word(w);
      check_value("ring_out idle word", 64'(ring_out), 64'(w));
      check_config();
      end_test();

      start_test("config registers");
      foreach (plain_ofs[i]) begin
         ring_write(plain_ofs[i], next_rand(), 1'b1);
         read_check(plain_ofs[i]);
      end
      check_config();
      foreach (worker_counts[i]) begin
         ring_write(6'(OFS_NUM_WORKERS), worker_counts[i], 1'b1);
         check_config();
      end
      foreach (proc_counts[i]) begin
         ring_write(6'(OFS_RT_OQ), proc_counts[i], 1'b1);
         check_config();
      end
      end_test();

      start_test("bad address");
      w = make_word(1'b1, BLOCK_TAG, 6'd12, next_rand());
      drive_word(w);
      check_value("ring_out bad read", 64'(ring_out), 64'(w));
      w = make_word(1'b0, BLOCK_TAG, 6'd12, next_rand());
      drive_word(w);
      check_value("ring_out bad write", 64'(ring_out), 64'(w));
      check_config();
      end_test();

      start_test("route table write");
      write_entry_regs();
      stored_entry = sh_entry;
      data         = next_rand();
      table_addr   = data[DEPTH_BITS-1:0];
      wr_req_count = 0;
      ring_write(6'(OFS_RT_WR_ADDR), data, 1'b0);
      check_value("rt_wr_req count", 64'(wr_req_count), 64'd1);
      check_value("rt_wr_entry.ip", 64'(seen_wr_entry.ip), 64'(stored_entry.ip));
      check_value("rt_wr_entry.mask", 64'(seen_wr_entry.mask), 64'(stored_entry.mask));
      check_value("rt_wr_entry.next_hop", 64'(seen_wr_entry.next_hop),
                  64'(stored_entry.next_hop));
      check_value("rt_wr_entry.oq", 64'(seen_wr_entry.oq), 64'(stored_entry.oq));
      check_value("rt_wr_addr", 64'(seen_wr_addr), 64'(table_addr));
      check_value("rt_wr_req after ack", 64'(rt_wr_req), 64'd0);
      read_check(6'(OFS_RT_WR_ADDR));
      end_test();

      start_test("route table read");
      write_entry_regs();
      check_config();                             // new entry before the fetch
      data         = next_rand();
      data[DEPTH_BITS-1:0] = table_addr;
      rd_req_count = 0;
      ring_write(6'(OFS_RT_RD_ADDR), data, 1'b0);
      sh_entry = stored_entry;
      check_value("rt_rd_req count", 64'(rd_req_count), 64'd1);
      check_value("rt_rd_addr", 64'(seen_rd_addr), 64'(table_addr));
      check_value("rt_rd_req after ack", 64'(rt_rd_req), 64'd0);
      for (int k = 3; k <= 7; k++) begin
         read_check(6'(k));
      end
      check_config();
      end_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
